/* hdl/conv_input_pkg.sv */
// widths, layout constants, payload typedefs and FSM state enums for the input-layer reader
package conv_input_pkg;

	// --------------------
	// bus and pixel widths
	localparam int ADDR_W = 32;
	localparam int PIXEL_W = 8;
	localparam int PIXELS_PER_BEAT = 8;
	localparam int BEAT_W = PIXELS_PER_BEAT * PIXEL_W;
	localparam int BEATS_PER_ROW = 8;
	localparam int DIM_W = 10;

	// --------------------
	// every ddr layer is 4k aligned and every row is one 64-byte burst
	localparam int ROW_STRIDE = 64;
	localparam int LAYER_STRIDE = 4096;
	localparam int MAX_COLS = 64;

	// --------------------
	// buffer geometry
	// slot 0 holds the row above, slot 1 the centre row, slot 2 the row below
	localparam int ROWS_PER_BANK = 3;
	localparam int BANKS = 2;
	localparam int ROW_W = BEAT_W * BEATS_PER_ROW;
	localparam int SLICE_W = 3 * PIXEL_W;
	localparam int WINDOW_W = ROWS_PER_BANK * SLICE_W;
	localparam int BANK_W = $clog2(BANKS);
	localparam int SLOT_IDX_W = $clog2(ROWS_PER_BANK);
	localparam int BEAT_IDX_W = $clog2(BEATS_PER_ROW);
	localparam int COL_IDX_W = $clog2(MAX_COLS);

	// axi response code for a clean read
	localparam logic [1:0] RESP_OKAY = 2'b00;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [BEAT_W-1:0] beat_t;
	typedef logic [DIM_W-1:0] dim_t;
	typedef logic [PIXEL_W-1:0] pixel_t;
	// top row in the msbs with each row ordered c-1, c, c+1 from the top byte down
	typedef logic [WINDOW_W-1:0] window_t;

	typedef enum logic [2:0] {
		fs_idle,
		fs_request,
		fs_receive,
		fs_publish,
		fs_wait_bank
	} fetch_state_t;

	typedef enum logic [1:0] {
		ss_wait_bank,
		ss_read,
		ss_present
	} stream_state_t;

endpackage

/* hdl/row_fetch.sv */
// scan sequencer, AXI4 read-burst master and free bank tracking for the row buffer
`timescale 1ns/1ps

module row_fetch (
	input  logic                                       clk,
	input  logic                                       reset_n,
	input  logic                                       start,
	input  conv_input_pkg::addr_t                      base_addr,
	input  conv_input_pkg::dim_t                       layer_count,
	input  conv_input_pkg::dim_t                       row_count,
	output conv_input_pkg::addr_t                      araddr,
	output logic                                       arvalid,
	input  logic                                       arready,
	input  logic                                       rvalid,
	input  logic                                       rlast,
	output logic                                       rready,
	input  logic [1:0]                                 rresp,
	output logic                                       wr_en,
	output logic [conv_input_pkg::BANK_W-1:0]          wr_bank,
	output logic [conv_input_pkg::SLOT_IDX_W-1:0]      wr_slot,
	output logic [conv_input_pkg::BEAT_IDX_W-1:0]      wr_beat,
	output logic                                       bank_filled,
	output logic [conv_input_pkg::BANK_W-1:0]          bank_id,
	output logic [conv_input_pkg::ROWS_PER_BANK-1:0]   row_mask,
	output logic                                       bank_last,
	input  logic                                       bank_free,
	output logic                                       busy
);
	import conv_input_pkg::*;

	fetch_state_t state;
	dim_t cur_row;
	dim_t cur_layer;
	dim_t src_row;
	logic [SLOT_IDX_W-1:0] slot;
	logic [BEAT_IDX_W-1:0] beat;
	logic [BANK_W-1:0] bank;
	logic [BANK_W:0] free_cnt;
	logic [BANK_W:0] free_next;
	logic [ROWS_PER_BANK-1:0] job_mask;
	logic job_last;
	logic jobs_done;

	// --------------------
	// job geometry
	// rows above and below only exist inside 0..row_count-1
	assign job_mask[0] = (cur_row != '0);
	assign job_mask[1] = 1'b1;
	assign job_mask[2] = ((cur_row + dim_t'(1)) < row_count);
	assign job_last = (cur_row == row_count - dim_t'(1)) &&
		(cur_layer == layer_count - dim_t'(1));

	// slot 0 at row 0 wraps here but is never requested
	assign src_row = cur_row + dim_t'(slot) - dim_t'(1);
	assign araddr = base_addr + addr_t'(cur_layer) * addr_t'(LAYER_STRIDE) +
		addr_t'(src_row) * addr_t'(ROW_STRIDE);

	// buffer never stalls, so rready is simply the receive state
	assign rready = (state == fs_receive);
	assign wr_en = rready && rvalid;
	assign wr_bank = bank;
	assign wr_slot = slot;
	assign wr_beat = beat;

	// bank info is valid during the publish cycle
	assign bank_filled = (state == fs_publish);
	assign bank_id = bank;
	assign row_mask = job_mask;
	assign bank_last = job_last;

	// returned banks in, published banks out
	always_comb begin
		free_next = free_cnt;
		if (bank_free)
			free_next = free_next + 1'b1;
		if (state == fs_publish)
			free_next = free_next - 1'b1;
	end

	// --------------------
	// sequencer FSM
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= fs_idle;
			arvalid <= 1'b0;
			busy <= 1'b0;
			cur_row <= '0;
			cur_layer <= '0;
			slot <= '0;
			beat <= '0;
			bank <= '0;
			free_cnt <= (BANK_W+1)'(BANKS);
			jobs_done <= 1'b0;
		end else begin
			free_cnt <= free_next;
			case (state)
				fs_idle: begin
					if (start) begin
						busy <= 1'b1;
						cur_row <= '0;
						cur_layer <= '0;
						jobs_done <= 1'b0;
						state <= fs_wait_bank;
					end
				end
				fs_wait_bank: begin
					// hold busy after the last job until every bank came back
					if (jobs_done) begin
						if (free_next == (BANK_W+1)'(BANKS)) begin
							busy <= 1'b0;
							state <= fs_idle;
						end
					end else if (free_cnt != '0) begin
						slot <= job_mask[0] ? SLOT_IDX_W'(0) : SLOT_IDX_W'(1);
						state <= fs_request;
					end
				end
				fs_request: begin
					// address is stable here and arvalid rises a cycle after entry
					if (!arvalid) begin
						arvalid <= 1'b1;
					end else if (arready) begin
						arvalid <= 1'b0;
						beat <= '0;
						state <= fs_receive;
					end
				end
				fs_receive: begin
					if (rvalid) begin
						beat <= beat + 1'b1;
						if (rlast) begin
							beat <= '0;
							if (slot == SLOT_IDX_W'(0)) begin
								slot <= SLOT_IDX_W'(1);
								state <= fs_request;
							end else if (slot == SLOT_IDX_W'(1) && job_mask[2]) begin
								slot <= SLOT_IDX_W'(2);
								state <= fs_request;
							end else begin
								state <= fs_publish;
							end
						end
					end
				end
				fs_publish: begin
					// banks keep alternating across runs too
					bank <= bank + 1'b1;
					jobs_done <= job_last;
					// layers inner, rows outer
					if (cur_layer == layer_count - dim_t'(1)) begin
						cur_layer <= '0;
						cur_row <= cur_row + dim_t'(1);
					end else begin
						cur_layer <= cur_layer + dim_t'(1);
					end
					state <= fs_wait_bank;
				end
				default: state <= fs_idle;
			endcase
		end
	end

	// --------------------
	// memory side checks
	// every burst is exactly one row
	a_rlast_on_row_end: assert property (@(posedge clk) disable iff (!reset_n)
		rvalid && rready |-> (rlast == (beat == BEAT_IDX_W'(BEATS_PER_ROW - 1))));

	a_rresp_okay: assert property (@(posedge clk) disable iff (!reset_n)
		rvalid |-> rresp == RESP_OKAY);

endmodule

/* hdl/row_buffer.sv */
// two-bank, three-slot row store with a registered three-column pixel read
`timescale 1ns/1ps

module row_buffer (
	input  logic                                    clk,
	input  logic                                    wr_en,
	input  logic [conv_input_pkg::BANK_W-1:0]       wr_bank,
	input  logic [conv_input_pkg::SLOT_IDX_W-1:0]   wr_slot,
	input  logic [conv_input_pkg::BEAT_IDX_W-1:0]   wr_beat,
	input  conv_input_pkg::beat_t                   wr_data,
	input  logic [conv_input_pkg::BANK_W-1:0]       rd_bank,
	input  conv_input_pkg::dim_t                    rd_col,
	output conv_input_pkg::window_t                 rd_pixels
);
	import conv_input_pkg::*;

	beat_t mem [BANKS][ROWS_PER_BANK][BEATS_PER_ROW];
	logic [ROW_W-1:0] row_bits [ROWS_PER_BANK];
	pixel_t px_l [ROWS_PER_BANK];
	pixel_t px_c [ROWS_PER_BANK];
	pixel_t px_r [ROWS_PER_BANK];
	logic [COL_IDX_W-1:0] col_c;
	logic [COL_IDX_W-1:0] col_l;
	logic [COL_IDX_W-1:0] col_r;

	// one write per accepted R beat
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_bank][wr_slot][wr_beat] <= wr_data;
	end

	// neighbour columns wrap inside the row and the stream zeroes them at the edges
	assign col_c = rd_col[COL_IDX_W-1:0];
	assign col_l = col_c - 1'b1;
	assign col_r = col_c + 1'b1;

	// --------------------
	// flatten each slot into a 64-byte row with byte n as column n
	always_comb begin
		for (int s = 0; s < ROWS_PER_BANK; s++) begin
			for (int b = 0; b < BEATS_PER_ROW; b++)
				row_bits[s][b*BEAT_W +: BEAT_W] = mem[rd_bank][s][b];
			px_l[s] = row_bits[s][col_l*PIXEL_W +: PIXEL_W];
			px_c[s] = row_bits[s][col_c*PIXEL_W +: PIXEL_W];
			px_r[s] = row_bits[s][col_r*PIXEL_W +: PIXEL_W];
		end
	end

	// read data follows rd_col by one cycle and is packed in window order
	always_ff @(posedge clk) begin
		for (int s = 0; s < ROWS_PER_BANK; s++)
			rd_pixels[WINDOW_W-1-s*SLICE_W -: SLICE_W] <= {px_l[s], px_c[s], px_r[s]};
	end

	// fetch only fills the bank the stream is not holding
	a_no_write_to_read_bank: assert property (@(posedge clk)
		wr_en |-> wr_bank != rd_bank);

endmodule

/* hdl/window_stream.sv */
// bank queue, column scan, zero padding and valid/ready output of 3x3 windows
`timescale 1ns/1ps

module window_stream (
	input  logic                                      clk,
	input  logic                                      reset_n,
	input  conv_input_pkg::dim_t                      col_count,
	input  logic                                      bank_filled,
	input  logic [conv_input_pkg::BANK_W-1:0]         bank_id,
	input  logic [conv_input_pkg::ROWS_PER_BANK-1:0]  row_mask,
	input  logic                                      bank_last,
	output logic                                      bank_free,
	output logic [conv_input_pkg::BANK_W-1:0]         rd_bank,
	output conv_input_pkg::dim_t                      rd_col,
	input  conv_input_pkg::window_t                   rd_pixels,
	output conv_input_pkg::window_t                   window_data,
	output logic                                      window_valid,
	input  logic                                      window_ready,
	output logic                                      window_last
);
	import conv_input_pkg::*;

	stream_state_t state;

	// one entry per published bank still to be drained
	logic [BANK_W-1:0] q_bank [BANKS];
	logic [ROWS_PER_BANK-1:0] q_mask [BANKS];
	logic q_last [BANKS];
	logic [BANK_W-1:0] q_wr_ptr;
	logic [BANK_W-1:0] q_rd_ptr;
	logic [BANK_W:0] q_count;
	logic q_pop;

	logic [ROWS_PER_BANK-1:0] cur_mask;
	logic cur_last;
	dim_t col;
	logic last_col;
	logic accept;
	window_t shaped;

	assign q_pop = (state == ss_wait_bank) && (q_count != '0);
	assign last_col = (col == col_count - dim_t'(1));
	assign accept = window_valid && window_ready;
	assign bank_free = accept && last_col;
	assign rd_col = col;

	// --------------------
	// bank queue
	always_ff @(posedge clk) begin
		if (bank_filled) begin
			q_bank[q_wr_ptr] <= bank_id;
			q_mask[q_wr_ptr] <= row_mask;
			q_last[q_wr_ptr] <= bank_last;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			q_wr_ptr <= '0;
			q_rd_ptr <= '0;
			q_count <= '0;
		end else begin
			if (bank_filled)
				q_wr_ptr <= q_wr_ptr + 1'b1;
			if (q_pop)
				q_rd_ptr <= q_rd_ptr + 1'b1;
			q_count <= q_count + (BANK_W+1)'(bank_filled) - (BANK_W+1)'(q_pop);
		end
	end

	// --------------------
	// zero the missing rows, column -1 at the left edge and column c+1 at the right edge
	always_comb begin
		shaped = rd_pixels;
		for (int s = 0; s < ROWS_PER_BANK; s++) begin
			if (!cur_mask[s])
				shaped[WINDOW_W-1-s*SLICE_W -: SLICE_W] = '0;
			if (col == '0)
				shaped[WINDOW_W-1-s*SLICE_W -: PIXEL_W] = '0;
			if (last_col)
				shaped[WINDOW_W-1-s*SLICE_W-2*PIXEL_W -: PIXEL_W] = '0;
		end
	end

	// --------------------
	// scan FSM steps through read, pixels back and window presented
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= ss_wait_bank;
			window_valid <= 1'b0;
			window_last <= 1'b0;
			// bank 0 is filled first, so park the read side on the other one
			rd_bank <= BANK_W'(BANKS - 1);
			cur_mask <= '0;
			cur_last <= 1'b0;
			col <= '0;
		end else begin
			case (state)
				ss_wait_bank: begin
					// rd_bank stays on the drained bank until the next one is ready
					if (q_pop) begin
						rd_bank <= q_bank[q_rd_ptr];
						cur_mask <= q_mask[q_rd_ptr];
						cur_last <= q_last[q_rd_ptr];
						col <= '0;
						state <= ss_read;
					end
				end
				ss_read: state <= ss_present;
				ss_present: begin
					if (!window_valid) begin
						window_valid <= 1'b1;
						window_last <= cur_last && last_col;
					end else if (window_ready) begin
						window_valid <= 1'b0;
						window_last <= 1'b0;
						if (last_col) begin
							state <= ss_wait_bank;
						end else begin
							col <= col + dim_t'(1);
							state <= ss_read;
						end
					end
				end
				default: state <= ss_wait_bank;
			endcase
		end
	end

	// capture while valid is still low, then hold under back-pressure
	always_ff @(posedge clk) begin
		if (state == ss_present && !window_valid)
			window_data <= shaped;
	end

	a_window_hold: assert property (@(posedge clk) disable iff (!reset_n)
		window_valid && !window_ready |=>
			window_valid && $stable(window_data) && $stable(window_last));

	// fetch never publishes more banks than it was given back
	a_queue_room: assert property (@(posedge clk) disable iff (!reset_n)
		bank_filled |-> q_count != (BANK_W+1)'(BANKS));

endmodule

/* hdl/input_layer_reader.sv */
// input-layer reader top level wiring the row fetch, row buffer and window stream stages
`timescale 1ns/1ps

// axi read bursts are fixed by convention to len 8, size 8 bytes, INCR and id 0
module input_layer_reader (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       start,
	input  conv_input_pkg::addr_t      base_addr,
	input  conv_input_pkg::dim_t       layer_count,
	input  conv_input_pkg::dim_t       row_count,
	input  conv_input_pkg::dim_t       col_count,
	output conv_input_pkg::addr_t      araddr,
	output logic                       arvalid,
	input  logic                       arready,
	input  conv_input_pkg::beat_t      rdata,
	input  logic [1:0]                 rresp,
	input  logic                       rlast,
	input  logic                       rvalid,
	output logic                       rready,
	output conv_input_pkg::window_t    window_data,
	output logic                       window_valid,
	input  logic                       window_ready,
	output logic                       window_last,
	output logic                       busy
);
	import conv_input_pkg::*;

	// fetch to buffer
	logic wr_en;
	logic [BANK_W-1:0] wr_bank;
	logic [SLOT_IDX_W-1:0] wr_slot;
	logic [BEAT_IDX_W-1:0] wr_beat;

	// fetch and stream handshake
	logic bank_filled;
	logic [BANK_W-1:0] bank_id;
	logic [ROWS_PER_BANK-1:0] row_mask;
	logic bank_last;
	logic bank_free;

	// stream to buffer
	logic [BANK_W-1:0] rd_bank;
	dim_t rd_col;
	window_t rd_pixels;

	// --------------------
	// stage 1 bursts rows in from ddr
	row_fetch u_row_fetch (
		.clk         (clk),
		.reset_n     (reset_n),
		.start       (start),
		.base_addr   (base_addr),
		.layer_count (layer_count),
		.row_count   (row_count),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rvalid      (rvalid),
		.rlast       (rlast),
		.rready      (rready),
		.rresp       (rresp),
		.wr_en       (wr_en),
		.wr_bank     (wr_bank),
		.wr_slot     (wr_slot),
		.wr_beat     (wr_beat),
		.bank_filled (bank_filled),
		.bank_id     (bank_id),
		.row_mask    (row_mask),
		.bank_last   (bank_last),
		.bank_free   (bank_free),
		.busy        (busy)
	);

	// stage 2 takes row data straight from the R channel into the banks
	row_buffer u_row_buffer (
		.clk       (clk),
		.wr_en     (wr_en),
		.wr_bank   (wr_bank),
		.wr_slot   (wr_slot),
		.wr_beat   (wr_beat),
		.wr_data   (rdata),
		.rd_bank   (rd_bank),
		.rd_col    (rd_col),
		.rd_pixels (rd_pixels)
	);

	// stage 3 sends the windows out
	window_stream u_window_stream (
		.clk          (clk),
		.reset_n      (reset_n),
		.col_count    (col_count),
		.bank_filled  (bank_filled),
		.bank_id      (bank_id),
		.row_mask     (row_mask),
		.bank_last    (bank_last),
		.bank_free    (bank_free),
		.rd_bank      (rd_bank),
		.rd_col       (rd_col),
		.rd_pixels    (rd_pixels),
		.window_data  (window_data),
		.window_valid (window_valid),
		.window_ready (window_ready),
		.window_last  (window_last)
	);

endmodule

/* verification/axi_ddr_model.sv */
// AXI4 read slave model with a formula-filled DDR, 8-beat bursts and optional random stalls
`timescale 1ns/1ps

module axi_ddr_model (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       stall_en,
	input  conv_input_pkg::addr_t      araddr,
	input  logic                       arvalid,
	output logic                       arready,
	output conv_input_pkg::beat_t      rdata,
	output logic [1:0]                 rresp,
	output logic                       rlast,
	output logic                       rvalid,
	input  logic                       rready
);
	import conv_input_pkg::*;

	logic active;
	addr_t burst_addr;
	logic [BEAT_IDX_W-1:0] beat;

	// every byte depends on the whole address
	function automatic pixel_t ddr_byte(input addr_t a);
		addr_t v;
		v = a * addr_t'(7) + (a >> 8);
		return v[PIXEL_W-1:0];
	endfunction

	// byte i of a beat is the lowest lane, little endian like the row buffer expects
	function automatic beat_t beat_at(input addr_t a, input int b);
		beat_t d;
		for (int i = 0; i < PIXELS_PER_BEAT; i++)
			d[i*PIXEL_W +: PIXEL_W] = ddr_byte(a + addr_t'(b * PIXELS_PER_BEAT + i));
		return d;
	endfunction

	// one in four cycles idles when stalls are on
	function automatic logic allow_cycle();
		return !stall_en || (($urandom % 4) != 0);
	endfunction

	assign rresp = RESP_OKAY;

	// --------------------
	// one address phase, then the eight R beats of that burst
	initial begin : slave
		int nb;
		arready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rdata = '0;
		active = 1'b0;
		beat = '0;
		burst_addr = '0;
		forever begin
			@(posedge clk);
			if (!reset_n) begin
				arready <= 1'b0;
				rvalid <= 1'b0;
				rlast <= 1'b0;
				active <= 1'b0;
				beat <= '0;
			end else if (!active) begin
				// address phase
				if (arvalid && arready) begin
					arready <= 1'b0;
					active <= 1'b1;
					burst_addr <= araddr;
					beat <= '0;
				end else begin
					arready <= allow_cycle();
				end
			end else if (rvalid && rready && rlast) begin
				rvalid <= 1'b0;
				rlast <= 1'b0;
				active <= 1'b0;
			end else begin
				// beat index to put on the bus next
				nb = int'(beat);
				if (rvalid && rready) begin
					nb = nb + 1;
					beat <= beat + BEAT_IDX_W'(1);
				end
				// a beat not yet taken stays on the bus
				if (!rvalid || rready) begin
					if (allow_cycle()) begin
						rvalid <= 1'b1;
						rdata <= beat_at(burst_addr, nb);
						rlast <= (nb == BEATS_PER_ROW - 1);
					end else begin
						rvalid <= 1'b0;
						rlast <= 1'b0;
					end
				end
			end
		end
	end

endmodule

/* verification/tb_input_layer_reader.sv */
// input-layer reader testbench with test table, reference windows, comparator and watchdog
`timescale 1ns/1ps

module tb_input_layer_reader;
	import conv_input_pkg::*;

	localparam int NTESTS = 8;

	// --------------------
	// one start per test table entry, run back to back
	string t_name [NTESTS] = '{"pad_3x5", "layers_4x9", "one_row", "one_col", "wide_64",
		"backpressure", "mem_stalls", "restart_mixed"};
	addr_t t_base [NTESTS] = '{32'h0010_0000, 32'h0003_4000, 32'h0007_8000, 32'h0001_0000,
		32'h00a0_0000, 32'h0002_2000, 32'h0003_4000, 32'h00c3_5000};
	int t_layers [NTESTS] = '{1, 3, 2, 1, 1, 2, 3, 2};
	int t_rows [NTESTS] = '{3, 4, 1, 3, 3, 3, 4, 5};
	int t_cols [NTESTS] = '{5, 9, 7, 1, 64, 9, 9, 16};
	bit t_bp [NTESTS] = '{0, 0, 0, 0, 0, 1, 0, 1};
	bit t_stall [NTESTS] = '{0, 0, 0, 0, 0, 0, 1, 1};

	logic clk;
	logic reset_n;
	logic start;
	addr_t base_addr;
	dim_t layer_count;
	dim_t row_count;
	dim_t col_count;
	addr_t araddr;
	logic arvalid;
	logic arready;
	beat_t rdata;
	logic [1:0] rresp;
	logic rlast;
	logic rvalid;
	logic rready;
	window_t window_data;
	logic window_valid;
	logic window_ready;
	logic window_last;
	logic busy;
	logic bp_en;
	logic stall_en;

	// parameters of the running test, read by the comparator
	string cur_name = "none";
	addr_t cur_base = '0;
	int cur_layers = 1;
	int cur_rows = 1;
	int cur_cols = 1;
	int total = 0;
	int first_idx = 0;
	int got = 0;
	logic held = 1'b0;
	window_t held_data;
	logic held_last;
	logic last_accept = 1'b0;
	int value_errors = 0;
	int stream_errors = 0;
	int flow_errors = 0;
	int cycles;
	int limit;

	input_layer_reader UUT (
		.clk(clk), .reset_n(reset_n), .start(start), .base_addr(base_addr),
		.layer_count(layer_count), .row_count(row_count), .col_count(col_count),
		.araddr(araddr), .arvalid(arvalid), .arready(arready), .rdata(rdata),
		.rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready),
		.window_data(window_data), .window_valid(window_valid),
		.window_ready(window_ready), .window_last(window_last), .busy(busy)
	);

	axi_ddr_model u_ddr (
		.clk(clk), .reset_n(reset_n), .stall_en(stall_en), .araddr(araddr),
		.arvalid(arvalid), .arready(arready), .rdata(rdata), .rresp(rresp),
		.rlast(rlast), .rvalid(rvalid), .rready(rready)
	);

	// --------------------
	// reference model
	// low byte of addr*7 + addr>>8 gives the byte at a ddr address
	function automatic pixel_t pattern_byte(input addr_t a);
		addr_t v;
		v = a * addr_t'(7) + (a >> 8);
		return v[PIXEL_W-1:0];
	endfunction

	// zero outside the feature map
	function automatic pixel_t padded_pixel(input addr_t base, input int layer, input int row,
		input int col, input int rows, input int cols);
		addr_t a;
		if (row < 0 || row >= rows || col < 0 || col >= cols)
			return '0;
		a = base + addr_t'(layer * LAYER_STRIDE + row * ROW_STRIDE + col);
		return pattern_byte(a);
	endfunction

	// top row first, c-1 first, so the first pixel lands in the msbs
	function automatic window_t expected_window(input addr_t base, input int layer,
		input int row, input int col, input int rows, input int cols);
		window_t w;
		w = '0;
		for (int dr = -1; dr <= 1; dr++)
			for (int dc = -1; dc <= 1; dc++)
				w = {w[WINDOW_W-PIXEL_W-1:0],
					padded_pixel(base, layer, row + dr, col + dc, rows, cols)};
		return w;
	endfunction

	task automatic report_counts();
		$display("windows %0d, value errors %0d, stream errors %0d, flow errors %0d",
			got, value_errors, stream_errors, flow_errors);
	endtask

	// start table entry t and wait for busy to drop
	task automatic run_test(input int t);
		@(posedge clk);
		cur_name <= t_name[t];
		cur_base <= t_base[t];
		cur_layers <= t_layers[t];
		cur_rows <= t_rows[t];
		cur_cols <= t_cols[t];
		total <= t_layers[t] * t_rows[t] * t_cols[t];
		first_idx <= got;
		bp_en <= t_bp[t];
		stall_en <= t_stall[t];
		base_addr <= t_base[t];
		layer_count <= dim_t'(t_layers[t]);
		row_count <= dim_t'(t_rows[t]);
		col_count <= dim_t'(t_cols[t]);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(posedge clk);
		if (!busy) begin
			flow_errors++;
			$display("%s: busy did not rise after start", t_name[t]);
		end
		while (busy)
			@(posedge clk);
		if (got - first_idx != t_layers[t] * t_rows[t] * t_cols[t]) begin
			flow_errors++;
			$display("CHECK FAILED %s window count at busy fall: expected %0d, actual %0d",
				t_name[t], t_layers[t] * t_rows[t] * t_cols[t], got - first_idx);
		end
		if (!last_accept) begin
			flow_errors++;
			$display("%s: busy did not fall in the cycle after the last window", t_name[t]);
		end
	endtask

	// --------------------
	// clock and stimulus
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// random back-pressure only when the test asks for it
	initial begin : ready_driver
		window_ready = 1'b0;
		forever begin
			@(posedge clk);
			window_ready <= bp_en ? 1'($urandom % 2) : 1'b1;
		end
	end

	initial begin
		void'($urandom(32'h4709));
		reset_n = 1'b0;
		start = 1'b0;
		base_addr = '0;
		layer_count = '0;
		row_count = '0;
		col_count = '0;
		bp_en = 1'b0;
		stall_en = 1'b0;
		repeat (8) @(posedge clk);
		reset_n <= 1'b1;
		for (int t = 0; t < NTESTS; t++)
			run_test(t);
		repeat (4) @(posedge clk);
		report_counts();
		if (value_errors + stream_errors + flow_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// --------------------
	// expected order is row, then layer, then column
	always @(posedge clk) begin : compare
		int idx;
		int c;
		int l;
		int r;
		window_t expw;
		logic exp_last;
		if (reset_n && held && (!window_valid || window_data !== held_data ||
			window_last !== held_last)) begin
			stream_errors++;
			$display("%s: window changed or dropped while held by back-pressure", cur_name);
		end
		if (reset_n && window_valid && window_ready) begin
			idx = got - first_idx;
			if (idx >= total) begin
				stream_errors++;
				$display("%s: extra window beyond the expected %0d", cur_name, total);
			end else begin
				c = idx % cur_cols;
				l = (idx / cur_cols) % cur_layers;
				r = idx / (cur_cols * cur_layers);
				expw = expected_window(cur_base, l, r, c, cur_rows, cur_cols);
				exp_last = (idx == total - 1);
				if (window_data !== expw) begin
					value_errors++;
					$display("CHECK FAILED %s row %0d layer %0d col %0d: expected %h, actual %h",
						cur_name, r, l, c, expw, window_data);
				end
				if (window_last !== exp_last) begin
					value_errors++;
					$display("CHECK FAILED %s last flag at window %0d: expected %b, actual %b",
						cur_name, idx, exp_last, window_last);
				end
			end
			got <= got + 1;
		end
		held <= reset_n && window_valid && !window_ready;
		held_data <= window_data;
		held_last <= window_last;
		last_accept <= reset_n && window_valid && window_ready && window_last;
	end

	// --------------------
	// budget per job covers three bursts plus the column scan
	initial begin : watchdog
		limit = 2000;
		for (int t = 0; t < NTESTS; t++)
			limit += t_layers[t] * t_rows[t] * (3 * 30 + t_cols[t] * 12);
		cycles = 0;
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", limit);
		report_counts();
		$display("** FAIL **");
		$finish;
	end

endmodule

/* build.f */
hdl/conv_input_pkg.sv
hdl/row_fetch.sv
hdl/row_buffer.sv
hdl/window_stream.sv
hdl/input_layer_reader.sv
verification/axi_ddr_model.sv
verification/tb_input_layer_reader.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_input_layer_reader
RTL_TOP  = input_layer_reader
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qxF '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(SIM) --lint-only -Wall --timing --assert --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
